// ==== soc_ctrl_pkg.sv ====
`default_nettype none

package soc_ctrl_pkg;

  localparam int unsigned ADDR_W     = 12;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned N_IO       = 64;
  localparam int unsigned PAD_IDX_W  = 6;
  localparam int unsigned PADCFG_W   = 6;
  localparam int unsigned PADMUX_W   = 2;
  localparam int unsigned WD_CNT_W   = 31;
  localparam int unsigned RTO_CNT_W  = 20;
  localparam int unsigned NB_MASTER  = 8;
  localparam int unsigned NB_CORES   = 4;
  localparam int unsigned NB_CLUSTERS = 1;
  localparam int unsigned JTAG_REG_W = 8;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    word_t;
  typedef logic [PAD_IDX_W-1:0] pad_idx_t;
  typedef logic [PADCFG_W-1:0]  pad_cfg_t;
  typedef logic [PADMUX_W-1:0]  pad_mux_t;
  typedef logic [WD_CNT_W-1:0]  wd_count_t;
  typedef logic [RTO_CNT_W-1:0] rto_count_t;

  localparam word_t BUILD_STAMP = 32'h5C0C_0001;

  // Register map
  localparam addr_t REG_INFO           = 12'h000;
  localparam addr_t REG_FCBOOT         = 12'h004;
  localparam addr_t REG_FCFETCH        = 12'h008;
  localparam addr_t REG_BUILD          = 12'h00C;
  localparam addr_t REG_WCFGFUN        = 12'h060;
  localparam addr_t REG_RCFGFUN        = 12'h064;
  localparam addr_t REG_JTAGREG        = 12'h074;
  localparam addr_t REG_BOOTSEL        = 12'h0C4;
  localparam addr_t REG_CLKSEL         = 12'h0C8;
  localparam addr_t REG_WD_COUNT       = 12'h0D0;
  localparam addr_t REG_WD_CONTROL     = 12'h0D4;
  localparam addr_t REG_RESET_REASON   = 12'h0D8;
  localparam addr_t REG_RTO_PERIPHERAL = 12'h0E0;
  localparam addr_t REG_RTO_COUNT      = 12'h0E4;
  localparam addr_t REG_EFPGA_RESET    = 12'h0E8;
  localparam addr_t REG_EFPGA_ENABLE   = 12'h0EC;
  localparam addr_t REG_EFPGA_CONTROL  = 12'h0F0;
  localparam addr_t REG_EFPGA_STATUS   = 12'h0F4;
  localparam addr_t REG_EFPGA_VERSION  = 12'h0F8;
  localparam addr_t REG_SOFT_RESET     = 12'h0FC;

  // Reset values and fixed codes
  localparam word_t      BOOTADDR_RST  = 32'h1A00_0080;
  localparam wd_count_t  WD_COUNT_RST  = 31'd32768;
  localparam rto_count_t RTO_COUNT_RST = 20'h000FF;
  localparam logic [15:0] WD_KICK_CODE = 16'h6699;
  localparam word_t      ERR_DATA      = 32'hDEAD_BEEF;
  localparam word_t      PAD_ERR_DATA  = 32'h0095_BEEF;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    WRITE,
    WAIT
  } bus_state_e;

endpackage

`default_nettype wire

// ==== soc_ctrl_regif.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl_regif (
  input  wire logic                              HCLK,
  input  wire logic                              HRESETn,
  input  wire soc_ctrl_pkg::addr_t               paddr_i,
  input  wire soc_ctrl_pkg::word_t               pwdata_i,
  input  wire logic                              pwrite_i,
  input  wire logic                              psel_i,
  input  wire logic                              penable_i,
  output soc_ctrl_pkg::word_t                    prdata_o,
  output logic                                   pready_o,
  output logic                                   pslverr_o,
  input  wire logic                              bootsel_i,
  input  wire logic                              dmactive_i,
  input  wire logic                              sel_fll_clk_i,
  input  wire logic [soc_ctrl_pkg::JTAG_REG_W-1:0] soc_jtag_reg_i,
  output logic [soc_ctrl_pkg::JTAG_REG_W-1:0]    soc_jtag_reg_o,
  input  wire soc_ctrl_pkg::word_t               efpga_status_i,
  input  wire logic [7:0]                        efpga_version_i,
  output soc_ctrl_pkg::word_t                    fc_bootaddr_o,
  output logic                                   fc_fetchen_o,
  output logic [3:0]                             efpga_reset_o,
  output logic [5:0]                             efpga_enable_o,
  output soc_ctrl_pkg::word_t                    efpga_control_o,
  output logic                                   soft_reset_o,
  output logic                                   pad_we_o,
  output soc_ctrl_pkg::pad_idx_t                 pad_wr_idx_o,
  output soc_ctrl_pkg::pad_cfg_t                 pad_wr_cfg_o,
  output soc_ctrl_pkg::pad_mux_t                 pad_wr_mux_o,
  output soc_ctrl_pkg::pad_idx_t                 pad_rd_idx_o,
  input  wire soc_ctrl_pkg::pad_cfg_t            pad_rd_cfg_i,
  input  wire soc_ctrl_pkg::pad_mux_t            pad_rd_mux_i,
  output logic                                   wd_count_we_o,
  output logic                                   wd_ctrl_we_o,
  output soc_ctrl_pkg::word_t                    wd_wdata_o,
  output logic                                   rr_clear_o,
  input  wire soc_ctrl_pkg::wd_count_t           wd_count_i,
  input  wire soc_ctrl_pkg::wd_count_t           wd_current_i,
  input  wire logic                              wd_enabled_i,
  input  wire logic [1:0]                        reset_reason_i,
  output logic                                   rto_count_we_o,
  output soc_ctrl_pkg::word_t                    rto_wdata_o,
  output logic                                   rto_flags_clear_o,
  input  wire soc_ctrl_pkg::rto_count_t          rto_count_i,
  input  wire logic [soc_ctrl_pkg::NB_MASTER-1:0] periph_rto_i
);
  import soc_ctrl_pkg::*;

  bus_state_e state;
  pad_idx_t   r_pad_idx;                        // Pad selected for RCFGFUN reads
  logic [JTAG_REG_W-1:0] jtag_sync_q1;
  logic [JTAG_REG_W-1:0] jtag_sync_q2;

  logic       in_window;
  logic [7:0] win_idx;
  logic       win_valid;
  logic       wr_act;
  logic       wr_hit;
  logic       rd_hit;
  word_t      rd_data;

  assign in_window = (paddr_i[11:10] == 2'b01);  // 0x400 to 0x7FC
  assign win_idx   = paddr_i[9:2];
  assign win_valid = (win_idx < 8'(N_IO));
  assign wr_act    = (state == WRITE);

  assign pad_wr_idx_o = in_window ? win_idx[PAD_IDX_W-1:0] : pwdata_i[PAD_IDX_W-1:0];
  assign pad_wr_cfg_o = in_window ? pwdata_i[8 +: PADCFG_W] : pwdata_i[24 +: PADCFG_W];
  assign pad_wr_mux_o = in_window ? pwdata_i[0 +: PADMUX_W] : pwdata_i[16 +: PADMUX_W];
  assign pad_rd_idx_o = in_window ? win_idx[PAD_IDX_W-1:0] : r_pad_idx;
  assign wd_wdata_o   = pwdata_i;
  assign rto_wdata_o  = pwdata_i;

  // Write decode and datapath strobes
  always_comb begin
    wr_hit            = 1'b1;
    pad_we_o          = 1'b0;
    wd_count_we_o     = 1'b0;
    wd_ctrl_we_o      = 1'b0;
    rto_count_we_o    = 1'b0;
    rto_flags_clear_o = 1'b0;
    if (in_window) begin
      pad_we_o = wr_act && win_valid;           // Out of range index is dropped
    end else begin
      case (paddr_i)
        REG_WCFGFUN:        pad_we_o = wr_act;
        REG_WD_COUNT:       wd_count_we_o = wr_act;
        REG_WD_CONTROL:     wd_ctrl_we_o = wr_act;
        REG_RTO_COUNT:      rto_count_we_o = wr_act;
        REG_RTO_PERIPHERAL: rto_flags_clear_o = wr_act;
        REG_FCBOOT, REG_FCFETCH, REG_RCFGFUN, REG_JTAGREG, REG_EFPGA_RESET,
        REG_EFPGA_ENABLE, REG_EFPGA_CONTROL, REG_SOFT_RESET: wr_hit = 1'b1;
        default:            wr_hit = 1'b0;
      endcase
    end
  end

  // Read mux
  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    if (in_window) begin
      rd_data = win_valid ? {18'h0, pad_rd_cfg_i, 6'h0, pad_rd_mux_i} : PAD_ERR_DATA;
    end else begin
      case (paddr_i)
        REG_INFO:           rd_data = {16'(NB_CORES), 16'(NB_CLUSTERS)};
        REG_FCBOOT:         rd_data = fc_bootaddr_o;
        REG_FCFETCH:        rd_data = {31'h0, fc_fetchen_o};
        REG_BUILD:          rd_data = BUILD_STAMP;
        REG_WCFGFUN, REG_RCFGFUN:
          rd_data = {2'b0, pad_rd_cfg_i, 6'h0, pad_rd_mux_i, 10'h0, r_pad_idx};
        REG_JTAGREG:        rd_data = word_t'({jtag_sync_q2, soc_jtag_reg_o});
        REG_BOOTSEL:        rd_data = {dmactive_i, bootsel_i, 30'h0};
        REG_CLKSEL:         rd_data = {31'h0, sel_fll_clk_i};
        REG_WD_COUNT:       rd_data = {1'b0, wd_count_i};
        REG_WD_CONTROL:     rd_data = {wd_enabled_i, wd_current_i};
        REG_RESET_REASON:   rd_data = {30'h0, reset_reason_i};
        REG_RTO_PERIPHERAL: rd_data = word_t'(periph_rto_i);
        REG_RTO_COUNT:      rd_data = word_t'(rto_count_i);
        REG_EFPGA_RESET:    rd_data = word_t'(efpga_reset_o);
        REG_EFPGA_ENABLE:   rd_data = word_t'(efpga_enable_o);
        REG_EFPGA_CONTROL:  rd_data = efpga_control_o;
        REG_EFPGA_STATUS:   rd_data = efpga_status_i;
        REG_EFPGA_VERSION:  rd_data = word_t'(efpga_version_i);
        default: begin
          rd_hit  = 1'b0;
          rd_data = ERR_DATA;
        end
      endcase
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      jtag_sync_q1 <= '0;
      jtag_sync_q2 <= '0;
    end else begin
      jtag_sync_q1 <= soc_jtag_reg_i;
      jtag_sync_q2 <= jtag_sync_q1;
    end
  end

  always_ff @(posedge HCLK) begin
    if (state == READ) begin
      prdata_o <= rd_data;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state           <= IDLE;
      pready_o        <= 1'b0;
      pslverr_o       <= 1'b0;
      soft_reset_o    <= 1'b0;
      rr_clear_o      <= 1'b0;
      r_pad_idx       <= '0;
      soc_jtag_reg_o  <= '0;
      fc_bootaddr_o   <= BOOTADDR_RST;
      fc_fetchen_o    <= 1'b1;                  // Core fetches out of reset
      efpga_reset_o   <= '0;
      efpga_enable_o  <= '0;
      efpga_control_o <= '0;
    end else begin
      soft_reset_o <= 1'b0;
      rr_clear_o   <= 1'b0;
      case (state)
        IDLE: begin
          if (psel_i && penable_i) begin
            state <= pwrite_i ? WRITE : READ;
          end
        end
        READ: begin
          state      <= WAIT;
          pready_o   <= 1'b1;
          pslverr_o  <= !rd_hit;
          rr_clear_o <= !in_window && (paddr_i == REG_RESET_REASON);  // Clear-on-read
          if (in_window && win_valid) begin
            r_pad_idx <= win_idx[PAD_IDX_W-1:0];
          end
        end
        WRITE: begin
          state     <= WAIT;
          pready_o  <= 1'b1;
          pslverr_o <= !wr_hit;
          if (in_window) begin
            if (win_valid) begin
              r_pad_idx <= win_idx[PAD_IDX_W-1:0];
            end
          end else begin
            case (paddr_i)
              REG_FCBOOT:        fc_bootaddr_o <= pwdata_i;
              REG_FCFETCH:       fc_fetchen_o <= pwdata_i[0];
              REG_WCFGFUN,
              REG_RCFGFUN:       r_pad_idx <= pwdata_i[PAD_IDX_W-1:0];
              REG_JTAGREG:       soc_jtag_reg_o <= pwdata_i[JTAG_REG_W-1:0];
              REG_EFPGA_RESET:   efpga_reset_o <= pwdata_i[3:0];
              REG_EFPGA_ENABLE:  efpga_enable_o <= pwdata_i[5:0];
              REG_EFPGA_CONTROL: efpga_control_o <= pwdata_i;
              REG_SOFT_RESET:    soft_reset_o <= 1'b1;
              default: ;
            endcase
          end
        end
        WAIT: begin
          state     <= IDLE;
          pready_o  <= 1'b0;
          pslverr_o <= 1'b0;
        end
        default: state <= IDLE;
      endcase
      if (soft_reset_o) begin                   // Restore configuration defaults
        r_pad_idx       <= '0;
        efpga_reset_o   <= '0;
        efpga_enable_o  <= '0;
        efpga_control_o <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== soc_pad_cfg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_pad_cfg_bank (
  input  wire logic                   HCLK,
  input  wire logic                   HRESETn,
  input  wire logic                   soft_reset_i,
  input  wire logic                   we_i,
  input  wire soc_ctrl_pkg::pad_idx_t wr_idx_i,
  input  wire soc_ctrl_pkg::pad_cfg_t wr_cfg_i,
  input  wire soc_ctrl_pkg::pad_mux_t wr_mux_i,
  input  wire soc_ctrl_pkg::pad_idx_t rd_idx_i,
  output soc_ctrl_pkg::pad_cfg_t      rd_cfg_o,
  output soc_ctrl_pkg::pad_mux_t      rd_mux_o,
  output soc_ctrl_pkg::pad_cfg_t [soc_ctrl_pkg::N_IO-1:0] pad_cfg_o,
  output soc_ctrl_pkg::pad_mux_t [soc_ctrl_pkg::N_IO-1:0] pad_mux_o
);
  import soc_ctrl_pkg::*;

  // Combinational read port
  assign rd_cfg_o = pad_cfg_o[rd_idx_i];
  assign rd_mux_o = pad_mux_o[rd_idx_i];

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      pad_cfg_o <= '1;                          // Pads come up with all config bits set
      pad_mux_o <= '0;
    end else if (soft_reset_i) begin
      pad_cfg_o <= '1;
      pad_mux_o <= '0;
    end else if (we_i) begin
      pad_cfg_o[wr_idx_i] <= wr_cfg_i;
      pad_mux_o[wr_idx_i] <= wr_mux_i;
    end
  end

endmodule

`default_nettype wire

// ==== soc_watchdog.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_watchdog (
  input  wire logic                    HCLK,
  input  wire logic                    HRESETn,
  input  wire logic                    wd_tick_i,
  input  wire logic                    stoptimer_i,
  input  wire logic                    count_we_i,
  input  wire logic                    ctrl_we_i,
  input  wire soc_ctrl_pkg::word_t     wdata_i,
  input  wire logic                    rr_clear_i,
  output soc_ctrl_pkg::wd_count_t      wd_count_o,
  output soc_ctrl_pkg::wd_count_t      wd_current_o,
  output logic                         wd_enabled_o,
  output logic [1:0]                   reset_reason_o,
  output logic                         wd_expired_o
);
  import soc_ctrl_pkg::*;

  logic kick;
  logic reload;
  logic tick_en;
  logic expire;

  assign kick    = ctrl_we_i && wd_enabled_o && (wdata_i[15:0] == WD_KICK_CODE);
  assign reload  = (ctrl_we_i && wdata_i[31]) || kick;
  assign tick_en = wd_tick_i && wd_enabled_o && !stoptimer_i && (wd_current_o != '0);
  assign expire  = tick_en && (wd_current_o == wd_count_t'(1));

  // Reload value and enable, locked once running
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wd_count_o   <= WD_COUNT_RST;
      wd_enabled_o <= 1'b0;
    end else begin
      if (count_we_i && !wd_enabled_o) begin
        wd_count_o <= wdata_i[WD_CNT_W-1:0];
      end
      if (ctrl_we_i && wdata_i[31]) begin
        wd_enabled_o <= 1'b1;                   // Only HRESETn disables it again
      end
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wd_current_o <= WD_COUNT_RST;
      wd_expired_o <= 1'b0;
    end else if (reload) begin
      wd_current_o <= wd_count_o;
      wd_expired_o <= 1'b0;
    end else if (tick_en) begin
      wd_current_o <= wd_current_o - wd_count_t'(1);
      if (expire) begin
        wd_expired_o <= 1'b1;                   // Held until the next reload
      end
    end
  end

  // Bit 0 power-on, bit 1 watchdog expiry
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      reset_reason_o <= 2'b01;
    end else begin
      if (rr_clear_i) begin
        reset_reason_o <= 2'b00;
      end
      if (expire) begin
        reset_reason_o[1] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== soc_rto_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_rto_monitor (
  input  wire logic                                HCLK,
  input  wire logic                                HRESETn,
  input  wire logic                                soft_reset_i,
  input  wire logic                                start_rto_i,
  input  wire logic [soc_ctrl_pkg::NB_MASTER-1:0]  peripheral_rto_i,
  input  wire logic                                count_we_i,
  input  wire soc_ctrl_pkg::word_t                 wdata_i,
  input  wire logic                                flags_clear_i,
  output soc_ctrl_pkg::rto_count_t                 rto_count_o,
  output logic [soc_ctrl_pkg::NB_MASTER-1:0]       periph_rto_o,
  output logic                                     rto_o
);
  import soc_ctrl_pkg::*;

  rto_count_t rto_cnt;                          // Running countdown

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      rto_count_o  <= RTO_COUNT_RST;
      periph_rto_o <= '0;
    end else if (soft_reset_i) begin
      rto_count_o  <= RTO_COUNT_RST;
      periph_rto_o <= '0;
    end else begin
      if (count_we_i) begin
        rto_count_o <= {wdata_i[19:4], 4'hF};   // Low nibble always set
      end
      if (flags_clear_i) begin
        periph_rto_o <= '0;
      end else begin
        periph_rto_o <= periph_rto_o | peripheral_rto_i;  // Sticky per master
      end
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      rto_cnt <= RTO_COUNT_RST;
      rto_o   <= 1'b0;
    end else begin
      rto_cnt <= start_rto_i ? rto_cnt - rto_count_t'(1) : rto_count_o;
      rto_o   <= (rto_cnt == '0);
    end
  end

endmodule

`default_nettype wire

// ==== soc_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl_top (
  input  wire logic                                HCLK,
  input  wire logic                                HRESETn,
  input  wire soc_ctrl_pkg::addr_t                 paddr_i,
  input  wire soc_ctrl_pkg::word_t                 pwdata_i,
  input  wire logic                                pwrite_i,
  input  wire logic                                psel_i,
  input  wire logic                                penable_i,
  output soc_ctrl_pkg::word_t                      prdata_o,
  output logic                                     pready_o,
  output logic                                     pslverr_o,
  input  wire logic                                bootsel_i,
  input  wire logic                                dmactive_i,
  input  wire logic                                sel_fll_clk_i,
  input  wire logic [soc_ctrl_pkg::JTAG_REG_W-1:0] soc_jtag_reg_i,
  output logic [soc_ctrl_pkg::JTAG_REG_W-1:0]      soc_jtag_reg_o,
  output soc_ctrl_pkg::word_t                      fc_bootaddr_o,
  output logic                                     fc_fetchen_o,
  input  wire soc_ctrl_pkg::word_t                 efpga_status_i,
  input  wire logic [7:0]                          efpga_version_i,
  output logic [3:0]                               efpga_reset_o,
  output logic [5:0]                               efpga_enable_o,
  output soc_ctrl_pkg::word_t                      efpga_control_o,
  output logic                                     soft_reset_o,
  output soc_ctrl_pkg::pad_cfg_t [soc_ctrl_pkg::N_IO-1:0] pad_cfg_o,
  output soc_ctrl_pkg::pad_mux_t [soc_ctrl_pkg::N_IO-1:0] pad_mux_o,
  input  wire logic                                wd_tick_i,
  input  wire logic                                stoptimer_i,
  output logic                                     wd_expired_o,
  input  wire logic                                start_rto_i,
  input  wire logic [soc_ctrl_pkg::NB_MASTER-1:0]  peripheral_rto_i,
  output logic                                     rto_o
);
  import soc_ctrl_pkg::*;

  logic       pad_we;
  pad_idx_t   pad_wr_idx;
  pad_cfg_t   pad_wr_cfg;
  pad_mux_t   pad_wr_mux;
  pad_idx_t   pad_rd_idx;
  pad_cfg_t   pad_rd_cfg;
  pad_mux_t   pad_rd_mux;
  logic       wd_count_we;
  logic       wd_ctrl_we;
  word_t      wd_wdata;
  logic       rr_clear;
  wd_count_t  wd_count;
  wd_count_t  wd_current;
  logic       wd_enabled;
  logic [1:0] reset_reason;
  logic       rto_count_we;
  word_t      rto_wdata;
  logic       rto_flags_clear;
  rto_count_t rto_count;
  logic [NB_MASTER-1:0] periph_rto;

  soc_ctrl_regif u_regif (
    .HCLK, .HRESETn,
    .paddr_i, .pwdata_i, .pwrite_i, .psel_i, .penable_i,
    .prdata_o, .pready_o, .pslverr_o,
    .bootsel_i, .dmactive_i, .sel_fll_clk_i,
    .soc_jtag_reg_i, .soc_jtag_reg_o,
    .efpga_status_i, .efpga_version_i,
    .fc_bootaddr_o, .fc_fetchen_o,
    .efpga_reset_o, .efpga_enable_o, .efpga_control_o,
    .soft_reset_o,
    .pad_we_o       (pad_we),
    .pad_wr_idx_o   (pad_wr_idx),
    .pad_wr_cfg_o   (pad_wr_cfg),
    .pad_wr_mux_o   (pad_wr_mux),
    .pad_rd_idx_o   (pad_rd_idx),
    .pad_rd_cfg_i   (pad_rd_cfg),
    .pad_rd_mux_i   (pad_rd_mux),
    .wd_count_we_o  (wd_count_we),
    .wd_ctrl_we_o   (wd_ctrl_we),
    .wd_wdata_o     (wd_wdata),
    .rr_clear_o     (rr_clear),
    .wd_count_i     (wd_count),
    .wd_current_i   (wd_current),
    .wd_enabled_i   (wd_enabled),
    .reset_reason_i (reset_reason),
    .rto_count_we_o (rto_count_we),
    .rto_wdata_o    (rto_wdata),
    .rto_flags_clear_o (rto_flags_clear),
    .rto_count_i    (rto_count),
    .periph_rto_i   (periph_rto)
  );

  soc_pad_cfg_bank u_pad_bank (
    .HCLK, .HRESETn,
    .soft_reset_i (soft_reset_o),
    .we_i     (pad_we),
    .wr_idx_i (pad_wr_idx),
    .wr_cfg_i (pad_wr_cfg),
    .wr_mux_i (pad_wr_mux),
    .rd_idx_i (pad_rd_idx),
    .rd_cfg_o (pad_rd_cfg),
    .rd_mux_o (pad_rd_mux),
    .pad_cfg_o, .pad_mux_o
  );

  soc_watchdog u_watchdog (
    .HCLK, .HRESETn,
    .wd_tick_i, .stoptimer_i,
    .count_we_i     (wd_count_we),
    .ctrl_we_i      (wd_ctrl_we),
    .wdata_i        (wd_wdata),
    .rr_clear_i     (rr_clear),
    .wd_count_o     (wd_count),
    .wd_current_o   (wd_current),
    .wd_enabled_o   (wd_enabled),
    .reset_reason_o (reset_reason),
    .wd_expired_o
  );

  soc_rto_monitor u_rto (
    .HCLK, .HRESETn,
    .soft_reset_i  (soft_reset_o),
    .start_rto_i, .peripheral_rto_i,
    .count_we_i    (rto_count_we),
    .wdata_i       (rto_wdata),
    .flags_clear_i (rto_flags_clear),
    .rto_count_o   (rto_count),
    .periph_rto_o  (periph_rto),
    .rto_o
  );

endmodule

`default_nettype wire

// ==== soc_ctrl_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl_assertions (
  input wire logic HCLK,
  input wire logic HRESETn,
  input wire logic psel_i,
  input wire logic penable_i,
  input wire logic pready_o,
  input wire logic pslverr_o,
  input wire logic soft_reset_o,
  input wire logic wd_expired_o,
  input wire logic rto_o
);

  int fail_count = 0;                           // Failed assertion attempts

  property ready_one_cycle;
    @(posedge HCLK) disable iff (!HRESETn)
      $rose(pready_o) |=> !pready_o;
  endproperty

  property slverr_with_ready;
    @(posedge HCLK) disable iff (!HRESETn)
      pslverr_o |-> pready_o;
  endproperty

  // First access cycle, one busy edge, then the response
  property ready_after_access;
    @(posedge HCLK) disable iff (!HRESETn)
      $rose(psel_i && penable_i) |-> ##1 !pready_o ##1 pready_o;
  endproperty

  property outputs_low_after_reset;
    @(posedge HCLK)
      $rose(HRESETn) |-> !(pready_o || pslverr_o || soft_reset_o || wd_expired_o || rto_o);
  endproperty

  ready_one_cycle_a: assert property (ready_one_cycle)
    else begin
      fail_count++;
      $error("pready_o stayed high for more than one cycle");
    end
  slverr_with_ready_a: assert property (slverr_with_ready)
    else begin
      fail_count++;
      $error("pslverr_o high without pready_o");
    end
  ready_after_access_a: assert property (ready_after_access)
    else begin
      fail_count++;
      $error("pready_o did not follow the access phase by two edges");
    end
  outputs_low_after_reset_a: assert property (outputs_low_after_reset)
    else begin
      fail_count++;
      $error("control outputs not low after reset");
    end

endmodule

`default_nettype wire

// ==== tb_soc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc_ctrl;
  import soc_ctrl_pkg::*;

  localparam int READY_TIMEOUT = 20;            // Cycles allowed for pready_o
  localparam int WD_TICKS      = 5;

  logic HCLK = 1'b0;
  logic HRESETn;
  addr_t paddr_i;
  word_t pwdata_i;
  logic pwrite_i;
  logic psel_i;
  logic penable_i;
  word_t prdata_o;
  logic pready_o;
  logic pslverr_o;
  logic bootsel_i;
  logic dmactive_i;
  logic sel_fll_clk_i;
  logic [JTAG_REG_W-1:0] soc_jtag_reg_i;
  logic [JTAG_REG_W-1:0] soc_jtag_reg_o;
  word_t fc_bootaddr_o;
  logic fc_fetchen_o;
  word_t efpga_status_i;
  logic [7:0] efpga_version_i;
  logic [3:0] efpga_reset_o;
  logic [5:0] efpga_enable_o;
  word_t efpga_control_o;
  logic soft_reset_o;
  pad_cfg_t [N_IO-1:0] pad_cfg_o;
  pad_mux_t [N_IO-1:0] pad_mux_o;
  logic wd_tick_i;
  logic stoptimer_i;
  logic wd_expired_o;
  logic start_rto_i;
  logic [NB_MASTER-1:0] peripheral_rto_i;
  logic rto_o;

  int errors = 0;
  int soft_reset_pulses = 0;
  integer seed;
  logic last_slverr;
  word_t last_rdata;
  word_t rdata;
  word_t rnd;
  word_t rto_expected;
  pad_idx_t idx;
  pad_cfg_t cfg;
  pad_mux_t mux;
  logic [NB_MASTER-1:0] flags_a;
  logic [NB_MASTER-1:0] flags_b;

  soc_ctrl_top dut (.*);

  bind soc_ctrl_top soc_ctrl_assertions u_assertions (
    .HCLK(HCLK), .HRESETn(HRESETn), .psel_i(psel_i), .penable_i(penable_i),
    .pready_o(pready_o), .pslverr_o(pslverr_o), .soft_reset_o(soft_reset_o),
    .wd_expired_o(wd_expired_o), .rto_o(rto_o)
  );

  always #5 HCLK = ~HCLK;

  always @(negedge HCLK) begin
    if (soft_reset_o) soft_reset_pulses++;    // One count per pulse
  end

  task automatic finish_run;
    int assert_fails;
    assert_fails = dut.u_assertions.fail_count;
    $display("Checks done with %0d errors and %0d assertion failures", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  task automatic compare_word(input string name, input word_t expected, input word_t actual);
    assert (actual == expected) else begin
      errors++;
      $display("Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // Setup cycle, access cycles until pready_o, then release
  task automatic drive_transfer(input addr_t addr, input word_t data, input logic write);
    int waited;
    waited = 0;
    @(negedge HCLK);
    paddr_i   = addr;
    pwdata_i  = data;
    pwrite_i  = write;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(negedge HCLK);
    penable_i = 1'b1;
    @(negedge HCLK);
    while (!pready_o && waited < READY_TIMEOUT) begin
      @(negedge HCLK);
      waited++;
    end
    if (!pready_o) begin
      errors++;
      $display("Error: the DUT never raised pready_o for address %h", addr);
      finish_run();
    end else begin
      last_rdata  = prdata_o;
      last_slverr = pslverr_o;
      psel_i      = 1'b0;
      penable_i   = 1'b0;
      pwrite_i    = 1'b0;
    end
  endtask

  task automatic apb_write(input addr_t addr, input word_t data);
    drive_transfer(addr, data, 1'b1);
  endtask

  task automatic apb_read(input addr_t addr, output word_t data);
    drive_transfer(addr, '0, 1'b0);
    data = last_rdata;
  endtask

  task automatic read_expect(input string name, input addr_t addr, input word_t expected);
    word_t data;
    apb_read(addr, data);
    compare_word(name, expected, data);
    compare_word({name, " pslverr_o"}, '0, {31'h0, last_slverr});
  endtask

  task automatic pulse_tick(input int count);
    repeat (count) begin
      @(negedge HCLK);
      wd_tick_i = 1'b1;
      @(negedge HCLK);
      wd_tick_i = 1'b0;
    end
  endtask

  task automatic pulse_periph(input logic [NB_MASTER-1:0] mask);
    @(negedge HCLK);
    peripheral_rto_i = mask;
    @(negedge HCLK);
    peripheral_rto_i = '0;
  endtask

  initial begin
    seed = 80218;
    HRESETn = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    pwrite_i = 1'b0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    bootsel_i = 1'b1;
    dmactive_i = 1'b0;
    sel_fll_clk_i = 1'b0;
    soc_jtag_reg_i = 8'hA5;
    efpga_status_i = 32'h0000_0003;
    efpga_version_i = 8'h12;
    wd_tick_i = 1'b0;
    stoptimer_i = 1'b0;
    start_rto_i = 1'b0;
    peripheral_rto_i = '0;
    repeat (2) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;

    // Identity and reset values
    read_expect("INFO", REG_INFO, word_t'((NB_CORES << 16) | NB_CLUSTERS));
    read_expect("FCBOOT reset", REG_FCBOOT, BOOTADDR_RST);
    read_expect("RTO_COUNT reset", REG_RTO_COUNT, word_t'(RTO_COUNT_RST));
    read_expect("BOOTSEL boot pin", REG_BOOTSEL, 32'h4000_0000);
    bootsel_i = 1'b0;
    dmactive_i = 1'b1;
    read_expect("BOOTSEL debug active", REG_BOOTSEL, 32'h8000_0000);
    read_expect("RESET_REASON power on", REG_RESET_REASON, 32'h1);
    read_expect("RESET_REASON cleared", REG_RESET_REASON, 32'h0);

    // Plain registers
    apb_write(REG_FCBOOT, 32'h1C00_8000);
    compare_word("fc_bootaddr_o", 32'h1C00_8000, fc_bootaddr_o);
    read_expect("FCBOOT", REG_FCBOOT, 32'h1C00_8000);
    apb_write(REG_FCFETCH, 32'h0);
    compare_word("fc_fetchen_o", 32'h0, {31'h0, fc_fetchen_o});
    read_expect("FCFETCH", REG_FCFETCH, 32'h0);
    rnd = $random(seed);
    apb_write(REG_EFPGA_CONTROL, rnd);
    compare_word("efpga_control_o", rnd, efpga_control_o);
    read_expect("EFPGA_CONTROL", REG_EFPGA_CONTROL, rnd);
    apb_write(REG_EFPGA_RESET, rnd);
    compare_word("efpga_reset_o", rnd & 32'hF, {28'h0, efpga_reset_o});
    read_expect("EFPGA_RESET", REG_EFPGA_RESET, rnd & 32'hF);
    apb_write(REG_EFPGA_ENABLE, rnd);
    compare_word("efpga_enable_o", rnd & 32'h3F, {26'h0, efpga_enable_o});
    read_expect("EFPGA_ENABLE", REG_EFPGA_ENABLE, rnd & 32'h3F);
    apb_write(REG_JTAGREG, 32'h0000_003C);
    compare_word("soc_jtag_reg_o", 32'h3C, {24'h0, soc_jtag_reg_o});
    soc_jtag_reg_i = 8'h5A;
    read_expect("JTAGREG", REG_JTAGREG, 32'h0000_5A3C);

    // Pads through the address window and through WCFGFUN/RCFGFUN
    repeat (6) begin
      rnd = $random(seed);
      idx = rnd[21:16];
      cfg = rnd[13:8];
      mux = rnd[1:0];
      apb_write({2'b01, 2'b00, idx, 2'b00}, rnd);
      compare_word("pad_cfg_o window", word_t'(cfg), word_t'(pad_cfg_o[idx]));
      compare_word("pad_mux_o window", word_t'(mux), word_t'(pad_mux_o[idx]));
      read_expect("pad window read", {2'b01, 2'b00, idx, 2'b00}, {18'h0, cfg, 6'h0, mux});
      rnd = $random(seed);
      idx = rnd[5:0];
      cfg = rnd[29:24];
      mux = rnd[17:16];
      apb_write(REG_WCFGFUN, rnd);
      compare_word("pad_cfg_o WCFGFUN", word_t'(cfg), word_t'(pad_cfg_o[idx]));
      compare_word("pad_mux_o WCFGFUN", word_t'(mux), word_t'(pad_mux_o[idx]));
      read_expect("RCFGFUN", REG_RCFGFUN, {2'b0, cfg, 6'h0, mux, 10'h0, idx});
    end
    rnd = $random(seed);
    read_expect("pad window out of range", {2'b01, 2'b01, rnd[5:0], 2'b00}, PAD_ERR_DATA);
    read_expect("pad window last slot", 12'h7FC, PAD_ERR_DATA);

    // Unmapped accesses
    apb_write(12'h010, 32'h1234_5678);
    compare_word("unmapped write pslverr_o", 32'h1, {31'h0, last_slverr});
    apb_read(12'h200, rdata);
    compare_word("unmapped read data", ERR_DATA, rdata);
    compare_word("unmapped read pslverr_o", 32'h1, {31'h0, last_slverr});

    // Watchdog
    apb_write(REG_WD_COUNT, WD_TICKS);
    read_expect("WD_COUNT", REG_WD_COUNT, WD_TICKS);
    apb_write(REG_WD_CONTROL, 32'h8000_0000);
    pulse_tick(WD_TICKS - 1);
    compare_word("wd_expired_o before kick", 32'h0, {31'h0, wd_expired_o});
    apb_write(REG_WD_CONTROL, 32'(WD_KICK_CODE));
    read_expect("WD_CONTROL after kick", REG_WD_CONTROL, 32'h8000_0000 | WD_TICKS);
    stoptimer_i = 1'b1;
    pulse_tick(2 * WD_TICKS);
    stoptimer_i = 1'b0;
    read_expect("WD_CONTROL while stopped", REG_WD_CONTROL, 32'h8000_0000 | WD_TICKS);
    pulse_tick(WD_TICKS - 1);
    compare_word("wd_expired_o one tick early", 32'h0, {31'h0, wd_expired_o});
    pulse_tick(1);
    compare_word("wd_expired_o at expiry", 32'h1, {31'h0, wd_expired_o});
    read_expect("RESET_REASON expiry", REG_RESET_REASON, 32'h2);

    // Ready timeout
    apb_write(REG_RTO_COUNT, 32'h0000_0040);
    rto_expected = (32'h0000_0040 & 32'h000F_FFF0) | 32'hF;
    read_expect("RTO_COUNT", REG_RTO_COUNT, rto_expected);
    start_rto_i = 1'b1;
    repeat (rto_expected) @(negedge HCLK);
    compare_word("rto_o before timeout", 32'h0, {31'h0, rto_o});
    @(negedge HCLK);
    compare_word("rto_o at timeout", 32'h1, {31'h0, rto_o});
    @(negedge HCLK);
    start_rto_i = 1'b0;
    rnd = $random(seed);
    flags_a = rnd[7:0];
    flags_b = rnd[15:8];
    pulse_periph(flags_a);
    pulse_periph(flags_b);
    read_expect("RTO_PERIPHERAL sticky", REG_RTO_PERIPHERAL, word_t'(flags_a | flags_b));
    apb_write(REG_RTO_PERIPHERAL, 32'h0);
    read_expect("RTO_PERIPHERAL cleared", REG_RTO_PERIPHERAL, 32'h0);

    // Soft reset
    apb_write(REG_SOFT_RESET, 32'h1);
    read_expect("EFPGA_CONTROL after soft reset", REG_EFPGA_CONTROL, 32'h0);
    read_expect("EFPGA_ENABLE after soft reset", REG_EFPGA_ENABLE, 32'h0);
    read_expect("RTO_COUNT after soft reset", REG_RTO_COUNT, word_t'(RTO_COUNT_RST));
    compare_word("soft_reset_o pulses", 32'h1, word_t'(soft_reset_pulses));
    compare_word("efpga_reset_o after soft reset", 32'h0, {28'h0, efpga_reset_o});
    for (int i = 0; i < N_IO; i++) begin
      compare_word("pad_cfg_o after soft reset", 32'h3F, word_t'(pad_cfg_o[i]));
      compare_word("pad_mux_o after soft reset", 32'h0, word_t'(pad_mux_o[i]));
    end

    finish_run();
  end

endmodule

`default_nettype wire

// ==== soc_ctrl_top.f ====
soc_ctrl_pkg.sv
soc_ctrl_regif.sv
soc_pad_cfg_bank.sv
soc_watchdog.sv
soc_rto_monitor.sv
soc_ctrl_top.sv
soc_ctrl_assertions.sv
tb_soc_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_ctrl \
  -f soc_ctrl_top.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || echo "Simulation FAILED" >> sim.log
cat sim.log
if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
exit 0
